// File: hw/emesh_pkg.sv
package emesh_pkg;

   //####################
   // Bus widths
   //####################
   localparam int AW = 32;                 // Address and data width
   localparam int PW = 2*AW + 40;          // Mesh packet, 104 bits

   //####################
   // Packet field map
   //####################
   localparam int WRITE_POS = 0;           // Write flag
   localparam int DM_LSB    = 1;           // Datamode
   localparam int DM_W      = 2;
   localparam int CTRL_LSB  = 3;           // Ctrlmode
   localparam int CTRL_W    = 5;
   localparam int DST_LSB   = 8;           // Destination address
   localparam int DATA_LSB  = DST_LSB + AW;
   localparam int SRC_LSB   = DATA_LSB + AW;  // Source address, top of packet

   // Widths with a meaning
   typedef logic [PW-1:0]     packet_t;
   typedef logic [AW-1:0]     addr_t;     // Byte address
   typedef logic [AW-1:0]     data_t;
   typedef logic [CTRL_W-1:0] ctrl_t;
   typedef logic [3:0]        be_t;       // One bit per byte lane

   // Access size
   typedef enum logic [DM_W-1:0] {
      dm_byte   = 2'd0,
      dm_half   = 2'd1,
      dm_word   = 2'd2,
      dm_double = 2'd3                    // Stored as a word
   } datamode_e;

endpackage

// File: hw/emesh_unpack.sv
`timescale 1ns/100ps
module emesh_unpack #(
   parameter int MEM_DEPTH = 256          // Words in the memory window
) (
   input  logic                 clk1,
   input  logic                 rst_n,
   input  logic                 access_in,
   input  emesh_pkg::packet_t   packet_in,
   input  logic                 wait_out,
   output logic                 wr_en,
   output logic                 rd_en,
   output emesh_pkg::addr_t     addr,
   output emesh_pkg::data_t     wr_data,
   output emesh_pkg::be_t       be,
   output emesh_pkg::addr_t     ret_addr,
   output emesh_pkg::datamode_e datamode,
   output emesh_pkg::ctrl_t     ctrlmode
);

   logic             ready_q;             // Endpoint out of reset
   logic             accept;
   logic             is_write;
   logic             in_window;
   emesh_pkg::data_t data;

   always_ff @(posedge clk1) begin
      if (!rst_n) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= 1'b1;
      end
   end

   // Field split
   assign is_write = packet_in[emesh_pkg::WRITE_POS];
   assign datamode = emesh_pkg::datamode_e'(packet_in[emesh_pkg::DM_LSB +: emesh_pkg::DM_W]);
   assign ctrlmode = packet_in[emesh_pkg::CTRL_LSB +: emesh_pkg::CTRL_W];
   assign addr     = packet_in[emesh_pkg::DST_LSB +: emesh_pkg::AW];
   assign data     = packet_in[emesh_pkg::DATA_LSB +: emesh_pkg::AW];
   assign ret_addr = packet_in[emesh_pkg::SRC_LSB +: emesh_pkg::AW];  // Reply goes here

   // Word index against window size
   assign in_window = (addr >> 2) < emesh_pkg::addr_t'(MEM_DEPTH);

   assign accept = access_in & ~wait_out & ready_q;   // Handshake edge
   assign wr_en  = accept & is_write & in_window;
   assign rd_en  = accept & ~is_write & in_window;     // Out of window dropped

   // Lane select and data replication
   always_comb begin
      case (datamode)
         emesh_pkg::dm_byte: begin
            be      = emesh_pkg::be_t'(4'b0001 << addr[1:0]);
            wr_data = {4{data[7:0]}};
         end
         emesh_pkg::dm_half: begin
            be      = addr[1] ? 4'b1100 : 4'b0011;   // Bit 0 ignored
            wr_data = {2{data[15:0]}};
         end
         default: begin                            // Word and double
            be      = 4'b1111;
            wr_data = data;
         end
      endcase
   end

endmodule

// File: hw/emesh_mem.sv
`timescale 1ns/100ps
module emesh_mem #(
   parameter int MEM_DEPTH = 256          // Number of 32-bit words
) (
   input  logic                 clk1,
   input  logic                 rst_n,
   input  logic                 wr_en,
   input  logic                 rd_en,
   input  emesh_pkg::addr_t     addr,
   input  emesh_pkg::data_t     wr_data,
   input  emesh_pkg::be_t       be,
   input  emesh_pkg::addr_t     ret_addr,
   input  emesh_pkg::datamode_e datamode,
   input  emesh_pkg::ctrl_t     ctrlmode,
   output logic                 rd_valid,
   output emesh_pkg::data_t     rd_data,
   output emesh_pkg::addr_t     rd_ret_addr,
   output emesh_pkg::datamode_e rd_datamode,
   output emesh_pkg::ctrl_t     rd_ctrlmode
);

   // Index width, at least one bit
   localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

   emesh_pkg::data_t mem_q [MEM_DEPTH];   // Word array
   logic [IDX_W-1:0] idx;

   // Byte address to word index
   assign idx = addr[IDX_W+1:2];

   //####################
   // Write port
   //####################
   always_ff @(posedge clk1) begin
      if (wr_en) begin
         for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
               mem_q[idx][8*i +: 8] <= wr_data[8*i +: 8];   // Enabled lanes only
            end
         end
      end
   end

   //####################
   // Read port
   //####################
   // Whole word back, return fields ride along
   always_ff @(posedge clk1) begin
      if (rd_en) begin
         rd_data     <= mem_q[idx];
         rd_ret_addr <= ret_addr;       // Requester srcaddr
         rd_datamode <= datamode;
         rd_ctrlmode <= ctrlmode;
      end
   end

   // One-cycle pulse per read
   always_ff @(posedge clk1) begin
      if (!rst_n) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= rd_en;
      end
   end

endmodule

// File: hw/emesh_resp.sv
`timescale 1ns/100ps
module emesh_resp (
   input  logic                 clk1,
   input  logic                 rst_n,
   input  logic                 rd_valid,
   input  emesh_pkg::data_t     rd_data,
   input  emesh_pkg::addr_t     rd_ret_addr,
   input  emesh_pkg::datamode_e rd_datamode,
   input  emesh_pkg::ctrl_t     rd_ctrlmode,
   input  logic                 rd_pending,     // Read accepted this cycle
   input  logic                 wait_in,
   output logic                 access_out,
   output emesh_pkg::packet_t   packet_out,
   output logic                 wait_out
);

   // Queue storage
   emesh_pkg::data_t     q_data [2];
   emesh_pkg::addr_t     q_addr [2];
   emesh_pkg::datamode_e q_dm   [2];
   emesh_pkg::ctrl_t     q_ctrl [2];

   logic       wr_ptr_q;
   logic       rd_ptr_q;
   logic [1:0] count_q;                    // 0 to 2 entries
   logic [1:0] count_nxt;
   logic       push;
   logic       pop;
   logic       wait_q;

   assign push       = rd_valid;               // Never full here
   assign access_out = (count_q != 2'd0);
   assign pop        = access_out & ~wait_in;  // Head held while wait_in
   assign count_nxt  = count_q + {1'b0, push} - {1'b0, pop};
   assign wait_out   = wait_q;

   always_ff @(posedge clk1) begin
      if (push) begin
         q_data[wr_ptr_q] <= rd_data;
         q_addr[wr_ptr_q] <= rd_ret_addr;
         q_dm[wr_ptr_q]   <= rd_datamode;
         q_ctrl[wr_ptr_q] <= rd_ctrlmode;
      end
   end

   //####################
   // Pointers and flow control
   //####################
   always_ff @(posedge clk1) begin
      if (!rst_n) begin
         wr_ptr_q <= 1'b0;
         rd_ptr_q <= 1'b0;
         count_q  <= 2'd0;
         wait_q   <= 1'b0;
      end else begin
         wr_ptr_q <= wr_ptr_q ^ push;
         rd_ptr_q <= rd_ptr_q ^ pop;
         count_q  <= count_nxt;
         // Entries next cycle plus a read then in flight
         wait_q   <= ({1'b0, count_nxt} + {2'b00, rd_pending}) >= 3'd2;
      end
   end

   // Reply packet from head entry
   always_comb begin
      packet_out = '0;                                          // srcaddr zero
      packet_out[emesh_pkg::WRITE_POS] = 1'b1;                  // Reply is a write
      packet_out[emesh_pkg::DM_LSB +: emesh_pkg::DM_W] = q_dm[rd_ptr_q];
      packet_out[emesh_pkg::CTRL_LSB +: emesh_pkg::CTRL_W] = q_ctrl[rd_ptr_q];
      packet_out[emesh_pkg::DST_LSB +: emesh_pkg::AW] = q_addr[rd_ptr_q];
      packet_out[emesh_pkg::DATA_LSB +: emesh_pkg::AW] = q_data[rd_ptr_q];
   end

endmodule

// File: hw/emesh_endpoint.sv
`timescale 1ns/100ps
module emesh_endpoint #(
   parameter int MEM_DEPTH = 256          // Memory size in words
) (
   input  logic               clk1,
   input  logic               rst_n,
   input  logic               access_in,
   input  emesh_pkg::packet_t packet_in,
   output logic               wait_out,
   output logic               access_out,
   output emesh_pkg::packet_t packet_out,
   input  logic               wait_in
);

   // Unpack to memory
   logic                 wr_en;
   logic                 rd_en;
   emesh_pkg::addr_t     addr;
   emesh_pkg::data_t     wr_data;
   emesh_pkg::be_t       be;
   emesh_pkg::addr_t     ret_addr;
   emesh_pkg::datamode_e datamode;
   emesh_pkg::ctrl_t     ctrlmode;

   // Memory to response queue
   logic                 rd_valid;
   emesh_pkg::data_t     rd_data;
   emesh_pkg::addr_t     rd_ret_addr;
   emesh_pkg::datamode_e rd_datamode;
   emesh_pkg::ctrl_t     rd_ctrlmode;

   //####################
   // Request decode
   //####################
   emesh_unpack #(.MEM_DEPTH(MEM_DEPTH)) unpack_i (
      .clk1      (clk1),
      .rst_n     (rst_n),
      .access_in (access_in),
      .packet_in (packet_in),
      .wait_out  (wait_out),          // Back pressure from queue
      .wr_en     (wr_en),
      .rd_en     (rd_en),
      .addr      (addr),
      .wr_data   (wr_data),
      .be        (be),
      .ret_addr  (ret_addr),
      .datamode  (datamode),
      .ctrlmode  (ctrlmode)
   );

   emesh_mem #(.MEM_DEPTH(MEM_DEPTH)) mem_i (
      .clk1        (clk1),
      .rst_n       (rst_n),
      .wr_en       (wr_en),
      .rd_en       (rd_en),
      .addr        (addr),
      .wr_data     (wr_data),
      .be          (be),
      .ret_addr    (ret_addr),
      .datamode    (datamode),
      .ctrlmode    (ctrlmode),
      .rd_valid    (rd_valid),
      .rd_data     (rd_data),
      .rd_ret_addr (rd_ret_addr),
      .rd_datamode (rd_datamode),
      .rd_ctrlmode (rd_ctrlmode)
   );

   //####################
   // Replies
   //####################
   emesh_resp resp_i (
      .clk1        (clk1),
      .rst_n       (rst_n),
      .rd_valid    (rd_valid),
      .rd_data     (rd_data),
      .rd_ret_addr (rd_ret_addr),
      .rd_datamode (rd_datamode),
      .rd_ctrlmode (rd_ctrlmode),
      .rd_pending  (rd_en),           // Read entering the memory
      .wait_in     (wait_in),
      .access_out  (access_out),
      .packet_out  (packet_out),
      .wait_out    (wait_out)
   );

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/100ps
module tb_clock #(
   parameter int PERIOD_NS    = 20,       // Clock period
   parameter int RESET_CYCLES = 16        // Cycles with rst_n low
) (
   output logic clk1,
   output logic rst_n
);

   initial begin
      clk1 = 1'b0;
      forever #(PERIOD_NS / 2) clk1 = ~clk1;
   end

   // Release just after a rising edge
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk1);
      #1 rst_n = 1'b1;
   end

endmodule

// File: bench/tb_endpoint.sv
`timescale 1ns/100ps
module tb_endpoint;

   localparam int MEM_DEPTH     = 256;   // Words as in the DUT
   localparam int MAX_ROWS      = 32;
   localparam int CYCLE_NS      = 20;
   localparam int RESET_CYCLES  = 16;
   localparam int ROW_CYCLES    = 40;    // Watchdog budget per row
   localparam int STALL_RELEASE = 4;     // Stalled cycles before wait_in drops

   logic               clk1;
   logic               rst_n;
   logic               access_in;
   emesh_pkg::packet_t packet_in;
   logic               wait_out;
   logic               access_out;
   emesh_pkg::packet_t packet_out;
   logic               wait_in;

   //####################
   // Stimulus and expect table
   //####################
   string                row_name    [MAX_ROWS];
   logic                 row_wr      [MAX_ROWS];
   emesh_pkg::datamode_e row_dm      [MAX_ROWS];
   emesh_pkg::ctrl_t     row_ctrl    [MAX_ROWS];
   emesh_pkg::addr_t     row_dst     [MAX_ROWS];
   emesh_pkg::data_t     row_data    [MAX_ROWS];
   emesh_pkg::addr_t     row_src     [MAX_ROWS];
   logic                 row_wait    [MAX_ROWS];   // wait_in while offered
   emesh_pkg::data_t     row_exp     [MAX_ROWS];
   logic                 row_exp_vld [MAX_ROWS];   // Reply expected
   int                   n_rows;

   emesh_pkg::data_t ref_mem [MEM_DEPTH];          // Reference word memory
   int               exp_q [$];                    // Rows awaiting replies in order
   integer           seed;
   logic             table_ready;
   logic             wait_seen;
   int               tests_run;
   int               tests_failed;
   int               other_errors;

   tb_clock #(.PERIOD_NS(CYCLE_NS), .RESET_CYCLES(RESET_CYCLES)) clock_i (
      .clk1  (clk1),
      .rst_n (rst_n)
   );

   emesh_endpoint #(.MEM_DEPTH(MEM_DEPTH)) emesh_endpoint_i (
      .clk1       (clk1),
      .rst_n      (rst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)
   );

   function automatic emesh_pkg::data_t next_random_word();
      return emesh_pkg::data_t'($random(seed));
   endfunction

   // Adds one row and updates the reference memory as the endpoint should
   task automatic add_row(input string name, input logic wr, input emesh_pkg::datamode_e dm,
                          input emesh_pkg::addr_t dst, input emesh_pkg::data_t data,
                          input emesh_pkg::addr_t src, input logic wt);
      logic in_win;
      int   word;
      int   lane;
      in_win = dst < emesh_pkg::addr_t'(MEM_DEPTH * 4);   // Byte address inside the window
      word   = in_win ? int'(dst >> 2) : 0;
      lane   = int'(dst[1:0]);
      row_name[n_rows]    = name;
      row_wr[n_rows]      = wr;
      row_dm[n_rows]      = dm;
      row_ctrl[n_rows]    = emesh_pkg::ctrl_t'(n_rows);   // Distinct per row
      row_dst[n_rows]     = dst;
      row_data[n_rows]    = data;
      row_src[n_rows]     = src;
      row_wait[n_rows]    = wt;
      row_exp[n_rows]     = '0;
      row_exp_vld[n_rows] = 1'b0;
      if (wr && in_win) begin
         case (dm)
            emesh_pkg::dm_byte: ref_mem[word][8*lane +: 8] = data[7:0];
            emesh_pkg::dm_half: begin
               if (dst[1]) begin
                  ref_mem[word][31:16] = data[15:0];   // Upper lane pair
               end else begin
                  ref_mem[word][15:0] = data[15:0];
               end
            end
            default: ref_mem[word] = data;             // Word and double
         endcase
      end else if (!wr && in_win) begin
         row_exp[n_rows]     = ref_mem[word];          // Whole word back
         row_exp_vld[n_rows] = 1'b1;
      end
      n_rows++;
   endtask

   task automatic build_table();
      add_row("word_wr_0", 1, emesh_pkg::dm_word, 32'h000, next_random_word(), 0, 0);
      add_row("word_wr_10", 1, emesh_pkg::dm_word, 32'h010, next_random_word(), 0, 0);
      add_row("word_rd_10", 0, emesh_pkg::dm_word, 32'h010, 0, 32'h8000_1000, 0);
      add_row("word_wr_20", 1, emesh_pkg::dm_word, 32'h020, next_random_word(), 0, 0);
      add_row("byte_wr_lane0", 1, emesh_pkg::dm_byte, 32'h020, next_random_word(), 0, 0);
      add_row("byte_wr_lane1", 1, emesh_pkg::dm_byte, 32'h021, next_random_word(), 0, 0);
      add_row("byte_wr_lane2", 1, emesh_pkg::dm_byte, 32'h022, next_random_word(), 0, 0);
      add_row("byte_wr_lane3", 1, emesh_pkg::dm_byte, 32'h023, next_random_word(), 0, 0);
      add_row("merge_rd_20", 0, emesh_pkg::dm_word, 32'h020, 0, 32'h0000_2220, 0);
      add_row("word_wr_30", 1, emesh_pkg::dm_word, 32'h030, next_random_word(), 0, 0);
      add_row("half_wr_low", 1, emesh_pkg::dm_half, 32'h030, next_random_word(), 0, 0);
      add_row("merge_rd_30_a", 0, emesh_pkg::dm_word, 32'h030, 0, 32'h0000_3330, 0);
      add_row("half_wr_high", 1, emesh_pkg::dm_half, 32'h032, next_random_word(), 0, 0);
      add_row("merge_rd_30_b", 0, emesh_pkg::dm_word, 32'h030, 0, 32'h0000_3332, 0);
      // Would alias word 0 if not dropped
      add_row("oow_wr_400", 1, emesh_pkg::dm_word, 32'h400, next_random_word(), 0, 0);
      add_row("oow_rd_400", 0, emesh_pkg::dm_word, 32'h400, 0, 32'h0000_1234, 0);
      add_row("oow_rd_high", 0, emesh_pkg::dm_word, 32'hFFFF_FFF0, 0, 32'h0000_5678, 0);
      add_row("word_rd_0", 0, emesh_pkg::dm_word, 32'h000, 0, 32'h0000_0100, 0);
      add_row("dbl_wr_40", 1, emesh_pkg::dm_double, 32'h040, next_random_word(), 0, 0);
      add_row("dbl_rd_40", 0, emesh_pkg::dm_double, 32'h040, 0, 32'h0000_4400, 0);
      add_row("top_wr_3fc", 1, emesh_pkg::dm_word, 32'h3FC, next_random_word(), 0, 0);
      // Reads stacked up behind wait_in
      add_row("bp_rd_10", 0, emesh_pkg::dm_word, 32'h010, 0, 32'hA000_0010, 1);
      add_row("bp_rd_20", 0, emesh_pkg::dm_word, 32'h020, 0, 32'hA000_0020, 1);
      add_row("bp_rd_30", 0, emesh_pkg::dm_word, 32'h030, 0, 32'hA000_0030, 1);
      add_row("bp_rd_3fc", 0, emesh_pkg::dm_word, 32'h3FC, 0, 32'hA000_03FC, 1);
      add_row("bp_rd_40", 0, emesh_pkg::dm_half, 32'h040, 0, 32'hA000_0040, 1);
      add_row("tail_rd_0", 0, emesh_pkg::dm_word, 32'h000, 0, 32'hB000_0000, 0);
      add_row("tail_wr_0", 1, emesh_pkg::dm_byte, 32'h001, next_random_word(), 0, 0);
      add_row("tail_rd_0b", 0, emesh_pkg::dm_word, 32'h000, 0, 32'hB000_0004, 0);
   endtask

   function automatic emesh_pkg::packet_t make_packet(input int row);
      emesh_pkg::packet_t p;
      p = '0;
      p[emesh_pkg::WRITE_POS]                        = row_wr[row];
      p[emesh_pkg::DM_LSB +: emesh_pkg::DM_W]        = row_dm[row];
      p[emesh_pkg::CTRL_LSB +: emesh_pkg::CTRL_W]    = row_ctrl[row];
      p[emesh_pkg::DST_LSB +: emesh_pkg::AW]         = row_dst[row];
      p[emesh_pkg::DATA_LSB +: emesh_pkg::AW]        = row_data[row];
      p[emesh_pkg::SRC_LSB +: emesh_pkg::AW]         = row_src[row];
      return p;
   endfunction

   //####################
   // Driver
   //####################
   // Entered and left 1 ns after a rising edge
   task automatic send_row(input int row);
      logic accepted;
      int   stall_cnt;
      accepted  = 1'b0;
      stall_cnt = 0;
      access_in = 1'b1;
      packet_in = make_packet(row);
      wait_in   = row_wait[row];
      while (!accepted) begin
         @(negedge clk1);
         if (!wait_out) begin
            accepted = 1'b1;                 // Taken at next edge
         end else begin
            wait_seen = 1'b1;
            @(posedge clk1);
            #1;
            stall_cnt++;
            if (stall_cnt >= STALL_RELEASE) begin
               wait_in = 1'b0;               // Let the queue drain
            end
         end
      end
      if (row_exp_vld[row]) begin
         exp_q.push_back(row);
      end
      @(posedge clk1);
      #1;
      if (!row_exp_vld[row]) begin
         tests_run++;
         $display("test %s done, no reply expected", row_name[row]);
      end
   endtask

   task automatic check_field(input int row, input string field, input logic [31:0] act,
                              input logic [31:0] exp, inout logic bad);
      if (act !== exp) begin
         $display("CHECK FAILED %s %s: expected %h actual %h", row_name[row], field, exp, act);
         bad = 1'b1;
      end
   endtask

   //####################
   // Reply monitor
   //####################
   task automatic check_reply(input emesh_pkg::packet_t pkt);
      int   row;
      logic bad;
      if (exp_q.size() == 0) begin
         other_errors++;
         $display("unexpected reply on access_out with no read outstanding, packet %h", pkt);
      end else begin
         row = exp_q.pop_front();            // Oldest request first
         bad = 1'b0;
         check_field(row, "write flag", {31'd0, pkt[emesh_pkg::WRITE_POS]}, 32'd1, bad);
         check_field(row, "datamode", {30'd0, pkt[emesh_pkg::DM_LSB +: emesh_pkg::DM_W]},
                     {30'd0, row_dm[row]}, bad);
         check_field(row, "ctrlmode", {27'd0, pkt[emesh_pkg::CTRL_LSB +: emesh_pkg::CTRL_W]},
                     {27'd0, row_ctrl[row]}, bad);
         check_field(row, "dstaddr", pkt[emesh_pkg::DST_LSB +: emesh_pkg::AW], row_src[row], bad);
         check_field(row, "data", pkt[emesh_pkg::DATA_LSB +: emesh_pkg::AW], row_exp[row], bad);
         check_field(row, "srcaddr", pkt[emesh_pkg::SRC_LSB +: emesh_pkg::AW], 32'd0, bad);
         tests_run++;
         if (bad) begin
            tests_failed++;
            $display("test %s failed", row_name[row]);
         end else begin
            $display("test %s ok, reply %h", row_name[row], row_exp[row]);
         end
      end
   endtask

   // Reply consumed at the next edge when wait_in is low
   always @(negedge clk1) begin
      if (rst_n === 1'b1 && access_out === 1'b1 && wait_in === 1'b0) begin
         check_reply(packet_out);
      end
   end

   initial begin
      access_in    = 1'b0;
      packet_in    = '0;
      wait_in      = 1'b0;
      seed         = 7619;
      n_rows       = 0;
      tests_run    = 0;
      tests_failed = 0;
      other_errors = 0;
      wait_seen    = 1'b0;
      table_ready  = 1'b0;
      build_table();
      table_ready = 1'b1;
      wait (rst_n === 1'b1);
      repeat (2) @(posedge clk1);
      @(negedge clk1);
      tests_run++;
      if (access_out !== 1'b0 || wait_out !== 1'b0) begin
         tests_failed++;
         $display("CHECK FAILED reset_idle access_out wait_out: expected 00 actual %b%b",
                  access_out, wait_out);
         $display("test reset_idle failed");
      end else begin
         $display("test reset_idle ok");
      end
      @(posedge clk1);
      #1;
      for (int i = 0; i < n_rows; i++) begin
         send_row(i);
      end
      access_in = 1'b0;
      wait_in   = 1'b0;
      while (exp_q.size() != 0) begin
         @(posedge clk1);
      end
      repeat (10) @(posedge clk1);           // Window for stray replies
      tests_run++;
      if (!wait_seen) begin
         tests_failed++;
         $display("test backpressure failed, wait_out never rose while replies were held");
      end else begin
         $display("test backpressure ok");
      end
      $display("tests run %0d, failed %0d, other errors %0d",
               tests_run, tests_failed, other_errors);
      if (tests_failed == 0 && other_errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // Watchdog budget scales with table length
   initial begin
      wait (table_ready === 1'b1);
      #((n_rows * ROW_CYCLES + RESET_CYCLES) * CYCLE_NS);
      $display("watchdog timeout, run did not finish, %0d replies still outstanding",
               exp_q.size());
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

// File: emesh_endpoint.f
hw/emesh_pkg.sv
hw/emesh_unpack.sv
hw/emesh_mem.sv
hw/emesh_resp.sv
hw/emesh_endpoint.sv
bench/tb_clock.sv
bench/tb_endpoint.sv

// File: Makefile
# Verilator build and run for the mesh memory endpoint

VERILATOR ?= verilator
TOP       ?= tb_endpoint
FILELIST  ?= emesh_endpoint.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
FAIL_MSG  ?= STATUS: FAIL

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, search $(LOG) for the fail line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS FAIL_MSG"

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
